// File: design/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result width, Q6.10
`define ALU_DATA_W 16

`define ALU_FRAC_W 10 // fraction bits

// raw opcode width on the port
`define ALU_OP_W 3

// saturation limits
`define ALU_SAT_MAX ({1'b0, {(`ALU_DATA_W-1){1'b1}}})
`define ALU_SAT_MIN ({1'b1, {(`ALU_DATA_W-1){1'b0}}})

`endif

// File: design/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_decode (
        input  wire logic                          clk_i,
        input  wire logic                          rst_n_i,
        input  wire logic                          req_i,
        input  wire logic [`ALU_OP_W-1:0]          op_i,
        input  wire logic signed [`ALU_DATA_W-1:0] src_a_i,
        input  wire logic signed [`ALU_DATA_W-1:0] src_b_i,
        input  wire logic                          idle_i,
        output logic                               dec_valid_o,
        output alu_pkg::alu_req_t                  dec_o
);

        logic              accept;
        alu_pkg::alu_op_e  op_dec;

        // result stage leaves idle on this same edge
        assign accept = req_i && idle_i;

        always_comb begin
                case (op_i)
                        `ALU_OP_W'd0: op_dec = alu_pkg::op_add;
                        `ALU_OP_W'd1: op_dec = alu_pkg::op_sub;
                        `ALU_OP_W'd2: op_dec = alu_pkg::op_mul;
                        `ALU_OP_W'd4: op_dec = alu_pkg::op_clz;
                        default:      op_dec = alu_pkg::op_illegal; // gelu, sort, spare codes
                endcase
        end

        always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                        dec_valid_o <= 1'b0;
                end else begin
                        dec_valid_o <= accept; // one cycle per accepted req
                end
        end

        // operands only move on an accept
        always_ff @(posedge clk_i) begin
                if (accept) begin
                        dec_o.op <= op_dec;
                        dec_o.a  <= src_a_i;
                        dec_o.b  <= src_b_i;
                end
        end

endmodule

`default_nettype wire

// File: design/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_execute (
        input  wire logic              clk_i,
        input  wire logic              rst_n_i,
        input  wire logic              dec_valid_i,
        input  wire alu_pkg::alu_req_t dec_i,
        output logic                   res_valid_o,
        output alu_pkg::alu_res_t      res_o
);

        localparam int PROD_W  = 2 * `ALU_DATA_W;
        localparam int TOP_LSB = `ALU_FRAC_W + `ALU_DATA_W - 1; // sign of the kept slice
        localparam int CNT_W   = $clog2(`ALU_DATA_W + 1);

        localparam logic signed [PROD_W-1:0]  ULP  = PROD_W'(1) << `ALU_FRAC_W;
        localparam logic [`ALU_FRAC_W-1:0]    HALF = {1'b1, {(`ALU_FRAC_W-1){1'b0}}};

        logic signed [`ALU_DATA_W-1:0] src_a;
        logic signed [`ALU_DATA_W-1:0] src_b;
        logic signed [`ALU_DATA_W-1:0] sum;
        logic signed [`ALU_DATA_W-1:0] diff;
        logic                          add_ovf;
        logic                          sub_ovf;
        logic signed [PROD_W-1:0]      prod;
        logic signed [PROD_W-1:0]      prod_rnd;
        logic [`ALU_FRAC_W-1:0]        frac;
        logic                          round_up;
        logic [PROD_W-TOP_LSB-1:0]     mul_top;
        logic                          mul_ovf;
        logic [CNT_W-1:0]              lz;
        alu_pkg::alu_res_t             res_d;

        assign src_a = dec_i.a;
        assign src_b = dec_i.b;

        // wrap first, then look at the signs
        assign sum     = src_a + src_b;
        assign diff    = src_a - src_b;
        assign add_ovf = (src_a[`ALU_DATA_W-1] == src_b[`ALU_DATA_W-1]) &&
                         (sum[`ALU_DATA_W-1] != src_a[`ALU_DATA_W-1]);
        assign sub_ovf = (src_a[`ALU_DATA_W-1] != src_b[`ALU_DATA_W-1]) &&
                         (diff[`ALU_DATA_W-1] != src_a[`ALU_DATA_W-1]);

        assign prod = src_a * src_b;
        assign frac = prod[`ALU_FRAC_W-1:0];

        // half-to-even at the fraction boundary
        assign round_up = (frac > HALF) || ((frac == HALF) && prod[`ALU_FRAC_W]);
        assign prod_rnd = round_up ? prod + ULP : prod;

        // bits above the kept slice must all match its sign
        assign mul_top = prod_rnd[PROD_W-1:TOP_LSB];
        assign mul_ovf = !((&mul_top) || !(|mul_top));

        // highest set bit wins, 16 when nothing is set
        always_comb begin
                lz = CNT_W'(`ALU_DATA_W);
                for (int i = 0; i < `ALU_DATA_W; i++) begin
                        if (src_a[i])
                                lz = CNT_W'(`ALU_DATA_W - 1 - i);
                end
        end

        always_comb begin
                res_d = '0;
                case (dec_i.op)
                        alu_pkg::op_add: begin
                                if (add_ovf)
                                        res_d.data = src_a[`ALU_DATA_W-1] ? `ALU_SAT_MIN : `ALU_SAT_MAX;
                                else
                                        res_d.data = sum;
                        end
                        alu_pkg::op_sub: begin
                                if (sub_ovf)
                                        res_d.data = src_a[`ALU_DATA_W-1] ? `ALU_SAT_MIN : `ALU_SAT_MAX;
                                else
                                        res_d.data = diff;
                        end
                        alu_pkg::op_mul: begin
                                if (mul_ovf)
                                        res_d.data = prod_rnd[PROD_W-1] ? `ALU_SAT_MIN : `ALU_SAT_MAX;
                                else
                                        res_d.data = prod_rnd[`ALU_FRAC_W +: `ALU_DATA_W];
                        end
                        alu_pkg::op_clz: res_d.data = {{(`ALU_DATA_W-CNT_W){1'b0}}, lz};
                        default:         res_d.err  = 1'b1; // data stays zero
                endcase
        end

        always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                        res_valid_o <= 1'b0;
                end else begin
                        res_valid_o <= dec_valid_i;
                end
        end

        always_ff @(posedge clk_i) begin
                if (dec_valid_i)
                        res_o <= res_d;
        end

endmodule

`default_nettype wire

// File: design/alu_pkg.sv
`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

        // decoded operation, raw codes 3/5/6/7 land on op_illegal
        typedef enum logic [`ALU_OP_W-1:0] {
                op_add     = `ALU_OP_W'd0,
                op_sub     = `ALU_OP_W'd1,
                op_mul     = `ALU_OP_W'd2,
                op_clz     = `ALU_OP_W'd4,
                op_illegal = `ALU_OP_W'd7
        } alu_op_e;

        typedef struct packed {
                alu_op_e                       op;
                logic signed [`ALU_DATA_W-1:0] a;
                logic signed [`ALU_DATA_W-1:0] b;
        } alu_req_t;

        typedef struct packed {
                logic signed [`ALU_DATA_W-1:0] data;
                logic                          err;
        } alu_res_t;

        // result stage handshake state
        typedef enum logic [1:0] {
                hs_idle = 2'd0,
                hs_busy = 2'd1,
                hs_ack  = 2'd2
        } hs_state_e;

endpackage

`default_nettype wire

// File: design/alu_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_result (
        input  wire logic                          clk_i,
        input  wire logic                          rst_n_i,
        input  wire logic                          req_i,
        input  wire logic                          accept_i,
        input  wire logic                          res_valid_i,
        input  wire alu_pkg::alu_res_t             res_i,
        output logic                               idle_o,
        output logic                               ack_o,
        output logic signed [`ALU_DATA_W-1:0]      data_o,
        output logic                               err_o
);

        alu_pkg::hs_state_e state_q;
        alu_pkg::hs_state_e state_d;
        logic               dec_seen_q; // decode launched the op now in flight
        logic               take;

        assign idle_o = (state_q == alu_pkg::hs_idle);
        assign ack_o  = (state_q == alu_pkg::hs_ack);
        assign take   = (state_q == alu_pkg::hs_busy) && res_valid_i && dec_seen_q;

        always_comb begin
                state_d = state_q;
                case (state_q)
                        alu_pkg::hs_idle: if (req_i) state_d = alu_pkg::hs_busy; // decode accepts too
                        alu_pkg::hs_busy: if (take)  state_d = alu_pkg::hs_ack;
                        alu_pkg::hs_ack:  if (!req_i) state_d = alu_pkg::hs_idle;
                        default:          state_d = alu_pkg::hs_idle;
                endcase
        end

        always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                        state_q    <= alu_pkg::hs_idle;
                        dec_seen_q <= 1'b0;
                        data_o     <= '0;
                        err_o      <= 1'b0;
                end else begin
                        state_q <= state_d;
                        if (accept_i)
                                dec_seen_q <= 1'b1;
                        else if (take)
                                dec_seen_q <= 1'b0;
                        // answer holds until the next one lands
                        if (take) begin
                                data_o <= res_i.data;
                                err_o  <= res_i.err;
                        end
                end
        end

endmodule

`default_nettype wire

// File: design/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_top (
        input  wire logic                          clk_i,
        input  wire logic                          rst_n_i,
        input  wire logic                          req_i,
        input  wire logic [`ALU_OP_W-1:0]          op_i,
        input  wire logic signed [`ALU_DATA_W-1:0] src_a_i,
        input  wire logic signed [`ALU_DATA_W-1:0] src_b_i,
        output logic                               ack_o,
        output logic signed [`ALU_DATA_W-1:0]      data_o,
        output logic                               err_o
);

        alu_pkg::alu_req_t dec;
        alu_pkg::alu_res_t res;
        logic              dec_valid;
        logic              res_valid;
        logic              idle;

        alu_decode u_decode (
                .clk_i       (clk_i),
                .rst_n_i     (rst_n_i),
                .req_i       (req_i),
                .op_i        (op_i),
                .src_a_i     (src_a_i),
                .src_b_i     (src_b_i),
                .idle_i      (idle),
                .dec_valid_o (dec_valid),
                .dec_o       (dec)
        );

        alu_execute u_execute (
                .clk_i       (clk_i),
                .rst_n_i     (rst_n_i),
                .dec_valid_i (dec_valid),
                .dec_i       (dec),
                .res_valid_o (res_valid),
                .res_o       (res)
        );

        // accept pulse doubles as decode's valid strobe
        alu_result u_result (
                .clk_i       (clk_i),
                .rst_n_i     (rst_n_i),
                .req_i       (req_i),
                .accept_i    (dec_valid),
                .res_valid_i (res_valid),
                .res_i       (res),
                .idle_o      (idle),
                .ack_o       (ack_o),
                .data_o      (data_o),
                .err_o       (err_o)
        );

endmodule

`default_nettype wire

// File: dv/alu_checks.svh
`ifndef ALU_CHECKS_SVH
`define ALU_CHECKS_SVH

// clamp a wide integer into the Q6.10 range
function automatic logic signed [`ALU_DATA_W-1:0] clamp_q(input int v);
        int hi;
        int lo;
        hi = (1 <<< (`ALU_DATA_W - 1)) - 1;
        lo = -(1 <<< (`ALU_DATA_W - 1));
        if (v > hi)
                return `ALU_SAT_MAX;
        if (v < lo)
                return `ALU_SAT_MIN;
        return v[`ALU_DATA_W-1:0];
endfunction

// product scaled down by 2^frac, nearest with ties to even
function automatic int mul_round(input logic signed [`ALU_DATA_W-1:0] a,
                                 input logic signed [`ALU_DATA_W-1:0] b);
        int p;
        int q;
        int r;
        int one;
        one = 1 <<< `ALU_FRAC_W;
        p = int'(a) * int'(b);
        q = p >>> `ALU_FRAC_W; // floor
        r = p - q * one;       // always 0 .. one-1
        if (r > one / 2 || (r == one / 2 && q[0]))
                q = q + 1;
        return q;
endfunction

function automatic alu_pkg::alu_res_t model_result(input logic [`ALU_OP_W-1:0] op,
                                                   input logic signed [`ALU_DATA_W-1:0] a,
                                                   input logic signed [`ALU_DATA_W-1:0] b);
        alu_pkg::alu_res_t res;
        res = '0;
        case (op)
                `ALU_OP_W'd0: res.data = clamp_q(int'(a) + int'(b));
                `ALU_OP_W'd1: res.data = clamp_q(int'(a) - int'(b));
                `ALU_OP_W'd2: res.data = clamp_q(mul_round(a, b));
                default:      res.err  = 1'b1; // random phase never lands here
        endcase
        return res;
endfunction

task automatic check_data(input alu_pkg::alu_res_t got, input alu_pkg::alu_res_t want);
        if (got.data !== want.data) begin
                $display("CHECK FAILED data_o got %h expected %h (op %0d a %h b %h)",
                         got.data, want.data, op_i, src_a_i, src_b_i);
                stop_run();
        end
endtask

task automatic check_err(input alu_pkg::alu_res_t got, input alu_pkg::alu_res_t want);
        if (got.err !== want.err) begin
                $display("CHECK FAILED err_o got %h expected %h (op %0d a %h b %h)",
                         got.err, want.err, op_i, src_a_i, src_b_i);
                stop_run();
        end
endtask

`endif

// File: dv/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_tb;

        localparam int          RESET_CYCLES  = 10;
        localparam int          RAND_OPS      = 64;
        localparam int          CYCLES_PER_OP = 20;
        localparam int          VEC_FIELDS    = 5; // op a b data err
        localparam int          VEC_MAX       = 64;
        localparam int          ACK_LATENCY   = 3; // falling edges from req_i to ack_o
        localparam logic [31:0] SEED          = 32'hfa8f7b01;

        logic                          clk_i;
        logic                          rst_n_i;
        logic                          req_i;
        logic [`ALU_OP_W-1:0]          op_i;
        logic signed [`ALU_DATA_W-1:0] src_a_i;
        logic signed [`ALU_DATA_W-1:0] src_b_i;
        logic                          ack_o;
        logic signed [`ALU_DATA_W-1:0] data_o;
        logic                          err_o;

        logic [15:0] vec_mem [0:VEC_FIELDS*VEC_MAX-1];
        int          n_vec;
        int          cycle_count = 0;
        int          cycle_limit = 0;

        alu_top uut (
                .clk_i   (clk_i),
                .rst_n_i (rst_n_i),
                .req_i   (req_i),
                .op_i    (op_i),
                .src_a_i (src_a_i),
                .src_b_i (src_b_i),
                .ack_o   (ack_o),
                .data_o  (data_o),
                .err_o   (err_o)
        );

        `include "alu_checks.svh"

        task automatic stop_run();
                $display("test failed");
                $fatal(1);
        endtask

        always #5 clk_i = ~clk_i;

        always @(posedge clk_i) begin
                cycle_count = cycle_count + 1;
                if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
                        $display("timeout after %0d cycles, the handshake hung", cycle_count);
                        stop_run();
                end
        end

        // one four-phase exchange, entered and left on a falling edge
        task automatic run_op(input logic [`ALU_OP_W-1:0] op,
                              input logic signed [`ALU_DATA_W-1:0] a,
                              input logic signed [`ALU_DATA_W-1:0] b,
                              input alu_pkg::alu_res_t want);
                int                lat;
                int                extra;
                alu_pkg::alu_res_t got;
                lat     = 0;
                op_i    = op;
                src_a_i = a;
                src_b_i = b;
                req_i   = 1'b1;
                while (ack_o !== 1'b1) begin
                        @(negedge clk_i);
                        lat++;
                end
                if (lat != ACK_LATENCY) begin
                        $display("ack_o rose %0d cycles after req_i, expected %0d", lat,
                                 ACK_LATENCY);
                        stop_run();
                end
                got.data = data_o;
                got.err  = err_o;
                check_data(got, want);
                check_err(got, want);
                extra = $urandom_range(0, 3); // back-pressure
                repeat (extra) begin
                        @(negedge clk_i);
                        if (ack_o !== 1'b1) begin
                                $display("ack_o dropped while req_i was still high");
                                stop_run();
                        end
                end
                req_i = 1'b0;
                @(negedge clk_i);
                if (ack_o !== 1'b0) begin
                        $display("ack_o still high one cycle after req_i dropped");
                        stop_run();
                end
                got.data = data_o; // answer must hold after release
                got.err  = err_o;
                check_data(got, want);
                check_err(got, want);
        endtask

        initial begin
                int                            i;
                int                            base;
                logic [31:0]                   seed_ret;
                logic [`ALU_OP_W-1:0]          op;
                logic signed [`ALU_DATA_W-1:0] a;
                logic signed [`ALU_DATA_W-1:0] b;
                alu_pkg::alu_res_t             want;

                clk_i    = 1'b0;
                rst_n_i  = 1'b0;
                req_i    = 1'b0;
                op_i     = '0;
                src_a_i  = '0;
                src_b_i  = '0;
                seed_ret = $urandom(SEED);

                for (i = 0; i < VEC_FIELDS * VEC_MAX; i++)
                        vec_mem[i] = 16'hffff; // end marker, no real op is ffff
                $readmemh("dv/alu_vectors.hex", vec_mem);
                n_vec = 0;
                while (n_vec < VEC_MAX && vec_mem[n_vec*VEC_FIELDS] != 16'hffff)
                        n_vec++;
                if (n_vec == 0) begin
                        $display("no vectors could be read from dv/alu_vectors.hex");
                        stop_run();
                end
                cycle_limit = CYCLES_PER_OP * (n_vec + RAND_OPS) + RESET_CYCLES;

                repeat (RESET_CYCLES) @(negedge clk_i);
                if (ack_o !== 1'b0) begin
                        $display("ack_o is not low during reset");
                        stop_run();
                end
                rst_n_i = 1'b1;
                @(negedge clk_i);
                if (ack_o !== 1'b0) begin
                        $display("ack_o is not low after reset");
                        stop_run();
                end

                for (i = 0; i < n_vec; i++) begin
                        base      = i * VEC_FIELDS;
                        want.data = vec_mem[base+3];
                        want.err  = vec_mem[base+4][0];
                        run_op(vec_mem[base][`ALU_OP_W-1:0], vec_mem[base+1],
                               vec_mem[base+2], want);
                end

                for (i = 0; i < RAND_OPS; i++) begin
                        op = `ALU_OP_W'($urandom_range(0, 2));
                        a  = `ALU_DATA_W'($urandom);
                        b  = `ALU_DATA_W'($urandom);
                        a  = a >>> $urandom_range(0, 7); // mix in small magnitudes
                        b  = b >>> $urandom_range(0, 7);
                        run_op(op, a, b, model_result(op, a, b));
                end

                $display("test passed");
                $finish;
        end

endmodule

`default_nettype wire

// File: dv/alu_vectors.hex
// op  a  b  expected data  expected err, all hex
// op 0 add, 1 sub, 2 mul, 4 clz, 3/5/6/7 illegal
0 0400 0400 0800 0
0 7000 1000 7fff 0
0 8000 ffff 8000 0
0 fc00 0200 fe00 0
0 7fff 0000 7fff 0
1 0800 0400 0400 0
1 7fff ffff 7fff 0
1 8000 0001 8000 0
1 0000 8000 7fff 0
1 0100 0300 fe00 0
2 0400 0400 0400 0
2 0600 0600 0900 0
2 0001 0200 0000 0
2 0003 0200 0002 0
2 ffff 0200 0000 0
2 fffd 0200 fffe 0
2 0001 0201 0001 0
2 0001 01ff 0000 0
2 7fff 7fff 7fff 0
2 7fff 8000 8000 0
2 8000 8000 7fff 0
2 2000 f000 8000 0
2 fc00 fc00 0400 0
4 0000 1234 0010 0
4 8000 0000 0000 0
4 ffff 0000 0000 0
4 0001 0000 000f 0
4 0002 0000 000e 0
4 0004 0000 000d 0
4 0008 0000 000c 0
4 0010 0000 000b 0
4 0020 0000 000a 0
4 0040 0000 0009 0
4 0080 0000 0008 0
4 0100 0000 0007 0
4 0200 0000 0006 0
4 0400 0000 0005 0
4 0800 0000 0004 0
4 1000 0000 0003 0
4 2000 0000 0002 0
4 4000 0000 0001 0
4 00ff 0000 0008 0
3 0400 0400 0000 1
5 1234 5678 0000 1
6 ffff 0001 0000 1
7 7fff 8000 0000 1

// File: run.sh
#!/bin/sh
# build and run the fixed-point ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=alu_sim
LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module alu_tb \
        -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
        echo "verilator build did not complete"
        exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
        echo "simulation exited with status $sim_status"
        exit 1
fi

# the log decides the verdict
if grep -q "test failed" "$LOG"; then
        exit 1
fi
exit 0

// File: vlog.f
+incdir+design
+incdir+dv
design/alu_pkg.sv
design/alu_decode.sv
design/alu_execute.sv
design/alu_result.sv
design/alu_top.sv
dv/alu_tb.sv
